//--- tm1637.f
source/tm1637_pkg.sv
source/step_rom.sv
source/step_sequencer.sv
source/tm1637_tx.sv
source/debug_leds.sv
source/tm1637_top.sv
bench/tm1637_asserts.sv
bench/tm1637_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tm1637_tb
FILELIST  = tm1637.f
OBJ_DIR   = obj_dir
RUN_FLAGS = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tm1637_tb.sv
// TM1637 sequencer testbench
`timescale 1ns/100ps

module tm1637_tb;

    localparam int reset_cycles      = 10;
    localparam int n_steps           = 5;      // Program length.
    localparam int max_step_cycles   = 70;     // 65-cycle transfer plus step overhead.
    localparam int quiet_cycles      = 200;    // Silence expected after halt.
    localparam int n_bytes           = 5;
    localparam int n_leds            = 5;
    localparam int led_settle_cycles = 2;      // View is registered.
    localparam int bit_half          = 4;      // Clock low or high, in cycles.
    localparam int first_start_time  = 20;     // Start time of step 0.
    localparam int test_cycles = reset_cycles + n_steps * max_step_cycles + quiet_cycles
                                 + n_leds * led_settle_cycles;
    localparam int watchdog_cycles = 4 * test_cycles;

    logic       temp_clk_led;
    logic       rst_n;
    logic [3:0] switches;      // Active low, as on the board.
    logic       tm_clk;
    logic       tm_dio;
    logic [3:0] led;

    // Bytes on the wire. The loop on step 2 sends the address command three times.
    logic [7:0] expected_bytes [0:n_bytes-1] = '{8'h40, 8'hC0, 8'hC0, 8'hC0, 8'h8F};

    // LED views after halt, by normalised switch code.
    logic [3:0] led_codes    [0:n_leds-1] = '{4'd0, 4'd3, 4'd4, 4'd1, 4'd9};
    logic [3:0] led_expected [0:n_leds-1] = '{4'b1101, 4'b0101, 4'b0011, 4'b0111, 4'b0110};

    int         cycle = 0;             // Rising edges of the clock.
    int         release_cycle = 0;     // Cycle when rst_n went high.
    int         first_fall_cycle = -1;
    int         edge_count = 0;        // Both edges of tm_clk.
    int         high_len = 0;          // Samples of the current high phase.
    int         low_len = 0;           // Samples of the current low phase.
    int         bit_count = 0;         // Bits captured in the current byte.
    logic       clk_prev = 1'b1;       // tm_clk idles high.
    logic [7:0] cur_byte = 8'h00;
    logic [7:0] captured [$];

    tm1637_top dut0 (
        .temp_clk_led (temp_clk_led),
        .rst_n        (rst_n),
        .switches     (switches),
        .tm_clk       (tm_clk),
        .tm_dio       (tm_dio),
        .led          (led)
    );

    always #2 temp_clk_led = ~temp_clk_led;    // 4 ns period.

    always @(posedge temp_clk_led) cycle <= cycle + 1;

    // Board switches are active low and wired in reverse order.
    function automatic logic [3:0] switches_for(input logic [3:0] code);
        return ~{code[0], code[1], code[2], code[3]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL t=%0t %s expected %0h got %0h", $time, name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "run stopped at first mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    // Pin monitor. Sampled mid-cycle, away from the clock edge.
    always @(negedge temp_clk_led) begin
        if (rst_n) begin
            if (dut0.tx0.sva0.failures != 0)
                abort_run("Concurrent assertions on the sender failed");
            if (dut0.tx_done)
                check_value("tm_clk last high phase", bit_half, high_len);
            if (tm_clk && !clk_prev) begin
                edge_count++;
                check_value("tm_clk low phase", bit_half, low_len);
                cur_byte = {tm_dio, cur_byte[7:1]};   // LSB arrives first.
                bit_count++;
                high_len = 1;
                if (bit_count == 8) begin
                    captured.push_back(cur_byte);
                    bit_count = 0;
                end
            end else if (!tm_clk && clk_prev) begin
                edge_count++;
                if (first_fall_cycle < 0)
                    first_fall_cycle = cycle;
                if (bit_count != 0)
                    check_value("tm_clk high phase", bit_half, high_len); // Between bits.
                low_len = 1;
            end else if (tm_clk) begin
                high_len++;
            end else begin
                low_len++;
            end
            clk_prev = tm_clk;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge temp_clk_led);
        abort_run($sformatf("Watchdog expired after %0d cycles", watchdog_cycles));
    end

    initial begin
        int i;
        int waited;
        int edges_before;
        temp_clk_led = 1'b0;
        rst_n        = 1'b0;
        switches     = switches_for(4'd0);

        // Reset state, checked after every edge of the reset window.
        repeat (reset_cycles) begin
            @(posedge temp_clk_led);
            #0.5;
            check_value("tm_clk in reset", 32'(1'b1), 32'(tm_clk));
            check_value("tm_dio in reset", 32'(1'b1), 32'(tm_dio));
            check_value("led in reset", 32'(4'b1111), 32'(led));
        end
        rst_n = 1'b1;
        release_cycle = cycle;

        @(posedge temp_clk_led);
        #0.5;
        check_value("tm_clk after reset", 32'(1'b1), 32'(tm_clk));
        check_value("tm_dio after reset", 32'(1'b1), 32'(tm_dio));
        check_value("led after reset", 32'(4'b1111), 32'(led));

        // Whole program, bounded by its worst-case length.
        waited = 0;
        while (captured.size() < n_bytes &&
               waited < first_start_time + n_steps * max_step_cycles) begin
            @(posedge temp_clk_led);
            waited++;
        end
        if (captured.size() < n_bytes)
            abort_run("Timed out waiting for the program's bytes on tm_clk and tm_dio");

        for (i = 0; i < n_bytes; i++)
            check_value($sformatf("byte %0d", i), 32'(expected_bytes[i]), 32'(captured[i]));

        if (first_fall_cycle - release_cycle < first_start_time)
            abort_run("First tm_clk fall came before the start time of step 0");

        // Halted, so the pins stay quiet.
        edges_before = edge_count;
        repeat (quiet_cycles) @(posedge temp_clk_led);
        check_value("tm_clk edges after halt", edges_before, edge_count);

        // Switch table, one view per entry.
        for (i = 0; i < n_leds; i++) begin
            @(posedge temp_clk_led);
            #0.5;
            switches = switches_for(led_codes[i]);
            repeat (led_settle_cycles) @(posedge temp_clk_led);
            #0.5;
            check_value($sformatf("led for code %0d", led_codes[i]),
                        32'(led_expected[i]), 32'(led));
        end

        if (dut0.tx0.sva0.failures == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run("Concurrent assertions on the sender failed");
        end
    end

endmodule

//--- bench/tm1637_asserts.sv
// Sender protocol assertions
`timescale 1ns/100ps

module tm1637_asserts (
    input logic temp_clk_led,
    input logic rst_n,
    input logic tx_start,
    input logic busy,        // Transfer in progress.
    input logic tm_clk,
    input logic tm_dio,
    input logic tx_done
);

    int failures = 0;        // Count of failed checks.

    // Done pulses for one cycle, 65 cycles after the start pulse.
    done_pulse: assert property (@(posedge temp_clk_led) disable iff (!rst_n)
        tx_start |-> ##65 tx_done ##1 !tx_done)
    else begin
        failures = failures + 1;
        $error("tx_done did not pulse once, 65 cycles after tx_start");
    end

    // A new byte only while idle.
    start_idle: assert property (@(posedge temp_clk_led) disable iff (!rst_n)
        tx_start |-> !busy)
    else begin
        failures = failures + 1;
        $error("tx_start arrived during a transfer");
    end

    // Data moves only under a low clock. The release after the last bit is a stop.
    dio_stable: assert property (@(posedge temp_clk_led) disable iff (!rst_n)
        (busy && $changed(tm_dio)) |-> !tm_clk)
    else begin
        failures = failures + 1;
        $error("tm_dio changed while tm_clk was high");
    end

endmodule

bind tm1637_tx tm1637_asserts sva0 (
    .temp_clk_led (temp_clk_led),
    .rst_n        (rst_n),
    .tx_start     (tx_start),
    .busy         (busy_q),
    .tm_clk       (tm_clk),
    .tm_dio       (tm_dio),
    .tx_done      (tx_done)
);

//--- source/tm1637_top.sv
// TM1637 sequencer top
`timescale 1ns/100ps

module tm1637_top import tm1637_pkg::*; (
    input  logic       temp_clk_led,
    input  logic       rst_n,      // Synchronous, active low.
    input  logic [3:0] switches,   // Active low debug select.
    output logic       tm_clk,     // To the display CLK pin.
    output logic       tm_dio,     // To the display DIO pin.
    output logic [3:0] led         // Active low debug LEDs.
);

    logic [step_addr_width-1:0] step_id;
    logic [step_word_width-1:0] step_word;
    logic                       tx_start;
    logic [byte_width-1:0]      tx_byte;
    logic                       tx_done;
    logic                       waiting_time;
    logic                       waiting_done;

    // Program store.
    step_rom rom0 (
        .step_id   (step_id),
        .step_word (step_word)
    );

    step_sequencer seq0 (
        .temp_clk_led (temp_clk_led),
        .rst_n        (rst_n),
        .step_word    (step_word),
        .tx_done      (tx_done),
        .step_id      (step_id),
        .tx_start     (tx_start),
        .tx_byte      (tx_byte),
        .waiting_time (waiting_time),
        .waiting_done (waiting_done)
    );

    // Serial pins.
    tm1637_tx tx0 (
        .temp_clk_led (temp_clk_led),
        .rst_n        (rst_n),
        .tx_start     (tx_start),
        .tx_byte      (tx_byte),
        .tm_clk       (tm_clk),
        .tm_dio       (tm_dio),
        .tx_done      (tx_done)
    );

    debug_leds leds0 (
        .temp_clk_led (temp_clk_led),
        .rst_n        (rst_n),
        .switches     (switches),
        .step_id      (step_id),
        .tm_clk       (tm_clk),
        .tm_dio       (tm_dio),
        .waiting_time (waiting_time),
        .waiting_done (waiting_done),
        .led          (led)
    );

endmodule

//--- source/debug_leds.sv
// Debug LED view
`timescale 1ns/100ps

module debug_leds import tm1637_pkg::*; (
    input  logic                       temp_clk_led,
    input  logic                       rst_n,
    input  logic [3:0]                 switches,     // Active low, SW4 on bit 0.
    input  logic [step_addr_width-1:0] step_id,
    input  logic                       tm_clk,
    input  logic                       tm_dio,
    input  logic                       waiting_time,
    input  logic                       waiting_done,
    output logic [3:0]                 led           // Active low.
);

    logic [3:0] norm_sw;  // Up = 1, SW4 is the MSB.
    logic [3:0] view;     // 1 = LED on.

    assign norm_sw = {~switches[0], ~switches[1], ~switches[2], ~switches[3]};

    always_comb begin
        case (norm_sw)
            led_view_step: view = step_id;
            // Clock pair ends up on led[3:2] after the flip.
            led_view_pins: view = {~tm_dio, tm_dio, ~tm_clk, tm_clk};
            led_view_wait: view = {waiting_time, waiting_done, 2'b11};
            default: begin
                view = norm_sw;                // Echo the switches.
            end
        endcase
    end

    // Invert for the active-low LEDs and reverse for the board order.
    always_ff @(posedge temp_clk_led) begin
        if (!rst_n)
            led <= 4'b1111;                    // All off.
        else
            led <= {~view[0], ~view[1], ~view[2], ~view[3]};
    end

endmodule

//--- source/tm1637_tx.sv
// TM1637 byte sender
`timescale 1ns/100ps

module tm1637_tx import tm1637_pkg::*; (
    input  logic                  temp_clk_led,
    input  logic                  rst_n,
    input  logic                  tx_start,  // Only arrives while idle.
    input  logic [byte_width-1:0] tx_byte,   // Sampled with tx_start.
    output logic                  tm_clk,    // Idle high.
    output logic                  tm_dio,    // Changes while tm_clk is low.
    output logic                  tx_done    // One cycle after the last bit.
);

    logic                     busy_q;   // Transfer in progress.
    logic [half_width-1:0]    half_q;   // Cycle within the current half.
    logic [bit_cnt_width-1:0] bit_q;    // Bit being sent, LSB first.
    logic [byte_width-1:0]    shift_q;  // Bit 0 is on the pin.

    logic load;      // Accept a new byte.
    logic half_end;  // Last cycle of a half period.
    logic last_bit;  // Bit 7 on the pin.
    logic next_bit;  // Move on to the following bit.

    assign load     = tx_start && !busy_q;
    assign half_end = half_q == half_width'(bit_half_cycles - 1);
    assign last_bit = bit_q == bit_cnt_width'(byte_width - 1);
    assign next_bit = busy_q && half_end && tm_clk && !last_bit;

    // Pins and counters. tm_clk doubles as the half-period phase.
    always_ff @(posedge temp_clk_led) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            half_q  <= '0;
            bit_q   <= '0;
            tm_clk  <= 1'b1;
            tm_dio  <= 1'b1;
            tx_done <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            if (load) begin
                busy_q <= 1'b1;
                half_q <= '0;
                bit_q  <= '0;
                tm_clk <= 1'b0;              // First low half.
                tm_dio <= tx_byte[0];
            end else if (busy_q) begin
                if (!half_end) begin
                    half_q <= half_q + 1'b1;
                end else begin
                    half_q <= '0;
                    if (!tm_clk) begin
                        tm_clk <= 1'b1;      // Device samples on this edge.
                    end else if (last_bit) begin
                        busy_q  <= 1'b0;
                        tm_dio  <= 1'b1;     // Release data, clock already high.
                        tx_done <= 1'b1;
                    end else begin
                        tm_clk <= 1'b0;
                        tm_dio <= shift_q[1]; // Next bit with the falling edge.
                        bit_q  <= bit_q + 1'b1;
                    end
                end
            end
        end
    end

    // Data shifter.
    always_ff @(posedge temp_clk_led) begin
        if (load)
            shift_q <= tx_byte;
        else if (next_bit)
            shift_q <= shift_q >> 1;
    end

endmodule

//--- source/step_sequencer.sv
// Step sequencer FSM
`timescale 1ns/100ps

module step_sequencer import tm1637_pkg::*; (
    input  logic                       temp_clk_led,
    input  logic                       rst_n,
    input  logic [step_word_width-1:0] step_word,    // From the ROM.
    input  logic                       tx_done,      // Pulse from the sender.
    output logic [step_addr_width-1:0] step_id,      // Address into the ROM.
    output logic                       tx_start,     // One-cycle start pulse.
    output logic [byte_width-1:0]      tx_byte,      // Held for the whole transfer.
    output logic                       waiting_time, // Start time not reached.
    output logic                       waiting_done  // Blocked on tx_done.
);

    // Decoded step fields.
    logic                    step_backward;
    logic [jump_width-1:0]   step_jump;
    logic                    step_halt;
    logic [start_width-1:0]  step_start;
    logic [byte_width-1:0]   step_data;
    logic                    step_marker;
    logic [repeat_width-1:0] step_count;
    logic                    step_write;
    logic                    step_wait;

    // Control state.
    logic                    exec_q;     // 0 = setup, 1 = execute.
    logic [time_width-1:0]   elapsed_q;  // Cycles since reset, in step time.
    logic [time_width-1:0]   saved_q;    // Elapsed time at the repeat marker.
    logic [repeat_width-1:0] repeat_q;   // Loops still to run.
    logic                    wait_q;     // Wait flag latched in setup.
    logic                    marker_q;   // Current step is a marker.

    logic time_wait;  // Step start time still ahead.
    logic setup_go;   // Setup phase acts this cycle.
    logic launch;     // Setup phase starts a transfer.

    assign step_backward = step_word[backward_bit];
    assign step_jump     = step_word[jump_msb:jump_lsb];
    assign step_halt     = step_word[halt_bit];
    assign step_start    = step_word[start_msb:start_lsb];
    assign step_data     = step_word[data_msb:data_lsb];
    assign step_marker   = step_word[marker_bit];
    assign step_count    = {step_word[marker_bit-1:0], step_data}; // 15-bit count.
    assign step_write    = step_word[write_bit] && !step_marker;
    assign step_wait     = step_word[wait_bit] && !step_marker;

    assign time_wait = elapsed_q < time_width'(step_start);
    assign setup_go  = !exec_q && !time_wait && !step_halt; // A halt step never leaves setup.
    assign launch    = setup_go && step_write;

    always_ff @(posedge temp_clk_led) begin
        if (!rst_n) begin
            step_id      <= '0;
            exec_q       <= 1'b0;
            elapsed_q    <= '0;
            saved_q      <= '0;
            repeat_q     <= '0;
            wait_q       <= 1'b0;
            marker_q     <= 1'b0;
            tx_start     <= 1'b0;
            waiting_time <= 1'b0;
            waiting_done <= 1'b0;
        end else begin
            tx_start <= 1'b0;                      // Pulse, one cycle only.
            if (time_wait) begin
                waiting_time <= 1'b1;
                elapsed_q    <= elapsed_q + 1'b1;  // Count up to the start time.
            end else begin
                waiting_time <= 1'b0;
                if (setup_go) begin
                    // Setup phase.
                    if (step_marker) begin
                        repeat_q <= step_count;
                        saved_q  <= elapsed_q + 1'b1; // Time to restore on each loop.
                    end
                    // No done pulse follows a step without a transfer.
                    wait_q   <= step_wait && step_write;
                    marker_q <= step_marker;
                    tx_start <= launch;
                    exec_q   <= 1'b1;
                end else if (exec_q) begin
                    // Execute phase.
                    if (wait_q && !tx_done) begin
                        waiting_done <= 1'b1;      // Transfer still running.
                    end else begin
                        waiting_done <= 1'b0;
                        exec_q       <= 1'b0;
                        if ((repeat_q != '0) && !marker_q) begin
                            repeat_q  <= repeat_q - 1'b1;
                            elapsed_q <= saved_q;
                            if (step_backward)
                                step_id <= step_id - step_addr_width'(step_jump);
                            else
                                step_id <= step_id + step_addr_width'(step_jump);
                        end else begin
                            step_id   <= step_id + 1'b1; // Next step in order.
                            elapsed_q <= elapsed_q + 1'b1;
                        end
                    end
                end
            end
        end
    end

    // Payload byte, captured with the start pulse.
    always_ff @(posedge temp_clk_led) begin
        if (launch)
            tx_byte <= step_data;
    end

endmodule

//--- source/step_rom.sv
// Display program ROM
`timescale 1ns/100ps

module step_rom import tm1637_pkg::*; (
    input  logic [step_addr_width-1:0] step_id,   // Step being fetched.
    output logic [step_word_width-1:0] step_word  // Encoded step, same cycle.
);

    // Word layout, high to low:
    //   [47] backward, [46:44] jump offset, [43] halt,
    //   [39:16] start time, [15:8] data byte,
    //   [7] repeat marker, [2] write, [0] wait.
    // A marker word reuses [6:0] as the top of its repeat count,
    // so its write and wait bits are zero by construction.

    always_comb begin
        case (step_id)
            // Data command, auto address increment.
            // Sent once the elapsed time reaches 20 cycles.
            4'd0: step_word = 48'h0000_0014_4005;

            // Repeat marker with a count of 2.
            // The following write is sent three times.
            4'd1: step_word = 48'h0000_0000_0280;

            // Address command for digit 0.
            // Backward offset 0, so the loop stays on this step.
            4'd2: step_word = 48'h8000_0000_C005;

            // Display control, on at full brightness.
            4'd3: step_word = 48'h0000_0000_8F05;

            // End of program.
            4'd4: step_word = halt_word;

            // Anything past the program halts as well.
            default: begin
                step_word = halt_word;
            end
        endcase
    end

endmodule

//--- source/tm1637_pkg.sv
// TM1637 sequencer definitions
package tm1637_pkg;

    // Step word geometry.
    localparam int step_word_width = 48;         // One program step.
    localparam int step_addr_width = 4;          // Up to 16 steps.

    // Field positions inside a step word.
    localparam int backward_bit = 47;            // Jump goes down when set.
    localparam int jump_msb     = 46;
    localparam int jump_lsb     = 44;
    localparam int jump_width   = jump_msb - jump_lsb + 1;
    localparam int halt_bit     = 43;            // Was a display power bit.
    localparam int start_msb    = 39;            // Start time, cycles from reset.
    localparam int start_lsb    = 16;
    localparam int start_width  = start_msb - start_lsb + 1;
    localparam int data_msb     = 15;            // Byte to send.
    localparam int data_lsb     = 8;
    localparam int marker_bit   = 7;             // Repeat marker.
    localparam int write_bit    = 2;             // Start a transfer.
    localparam int wait_bit     = 0;             // Hold until done.

    // Counter widths.
    localparam int time_width   = 28;            // Elapsed time.
    localparam int repeat_width = 15;            // Low marker bits plus data byte.

    // Word that stops the sequencer; also fills unused addresses.
    localparam logic [step_word_width-1:0] halt_word = 48'h0800_0000_0000;

    // Serial transfer.
    localparam int byte_width      = 8;
    localparam int bit_half_cycles = 4;          // Clock low, then clock high, per bit.
    localparam int half_width      = $clog2(bit_half_cycles);
    localparam int bit_cnt_width   = $clog2(byte_width);

    // Normalised switch codes for the LED views.
    localparam logic [3:0] led_view_step = 4'd0; // Current step index.
    localparam logic [3:0] led_view_pins = 4'd3; // Clock and data pins.
    localparam logic [3:0] led_view_wait = 4'd4; // Sequencer wait flags.

endpackage
